//--- design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define XLEN     32              // data and address width
`define REG_AW   5               // register index width
`define RESET_PC 32'h0000_0000   // first fetch after reset

// memory operation, stores have bit 3 set
`define MEM_NONE 4'b0000
`define MEM_LB   4'b0001
`define MEM_LH   4'b0010
`define MEM_LW   4'b0011
`define MEM_LBU  4'b0100
`define MEM_LHU  4'b0101
`define MEM_SB   4'b1110
`define MEM_SH   4'b1111
`define MEM_SW   4'b1000

// alu function, {bit 30, funct3} for the alu ops
`define ALU_ADD  4'b0000
`define ALU_SLL  4'b0001
`define ALU_SLT  4'b0010
`define ALU_SLTU 4'b0011
`define ALU_XOR  4'b0100
`define ALU_SRL  4'b0101
`define ALU_OR   4'b0110
`define ALU_AND  4'b0111
`define ALU_SUB  4'b1000
`define ALU_SRA  4'b1101
// branch compares share the table
`define ALU_BEQ  4'b1000   // beq and bne, same as sub
`define ALU_BLT  4'b0010   // same as slt
`define ALU_BLTU 4'b0011   // same as sltu
`define ALU_BGE  4'b1001
`define ALU_BGEU 4'b1010

// writeback select
`define WB_ALU   3'b000
`define WB_PC4   3'b001
`define WB_IMM   3'b011
`define WB_AUIPC 3'b100
`define WB_LOAD  3'b111

// operand b select
`define B_REG    2'b00
`define B_IMM    2'b01
`define B_SHAMT  2'b10

// major opcodes
`define OP_LOAD   7'b000_0011
`define OP_IMM    7'b001_0011
`define OP_AUIPC  7'b001_0111
`define OP_STORE  7'b010_0011
`define OP_REG    7'b011_0011
`define OP_LUI    7'b011_0111
`define OP_BRANCH 7'b110_0011
`define OP_JALR   7'b110_0111
`define OP_JAL    7'b110_1111

`endif

//--- design/rv_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]   word_t;      // data or address word
    typedef logic [`REG_AW-1:0] reg_addr_t;  // x0..x31
    typedef logic [3:0]         alu_fn_t;    // alu function code
    typedef logic [3:0]         mem_op_t;    // load/store kind
    typedef logic [2:0]         wb_sel_t;    // writeback source
    typedef logic [1:0]         b_sel_t;     // reg, imm or shamt
    typedef logic [3:0]         byte_en_t;   // one per byte lane

endpackage

`default_nettype wire

//--- design/ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

// decoded control from decoder to datapath
interface ctrl_if import rv_pkg::*; ();

    alu_fn_t alu_fn;  // alu op or branch compare
    b_sel_t  b_sel;   // operand b source
    wb_sel_t wb_sel;  // result to rd
    logic    rd_we;   // rd written this cycle
    logic    branch;  // conditional branch
    logic    bneq;    // invert equal test for bne
    logic    jal;
    logic    jalr;
    mem_op_t mem_op;  // load/store kind

    modport dec (
        output alu_fn, b_sel, wb_sel, rd_we, branch, bneq, jal, jalr, mem_op
    );

    modport dp (
        input alu_fn, b_sel, wb_sel, rd_we, branch, bneq, jal, jalr, mem_op
    );

endinterface

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module instr_decoder import rv_pkg::*; (
    input  word_t i_instr,  // instruction being retired
    ctrl_if.dec   ctrl      // control fields out
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;    // funct7 0000000
    logic       f7_alt;     // funct7 0100000, bit 30 set
    logic       rtype, itype, ltype, stype, btype, jtype, jrtype, lui, aupc;
    logic       r_ok, i_ok, l_ok, s_ok, b_ok, jr_ok;
    logic       imm_shift;  // slli, srli, srai
    logic       imm_sra;    // srai only

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign f7_zero = (funct7 == 7'b000_0000);
    assign f7_alt  = (funct7 == 7'b010_0000);

    // opcode groups
    assign rtype  = (opcode == `OP_REG);
    assign itype  = (opcode == `OP_IMM);
    assign ltype  = (opcode == `OP_LOAD);
    assign stype  = (opcode == `OP_STORE);
    assign btype  = (opcode == `OP_BRANCH);
    assign jtype  = (opcode == `OP_JAL);
    assign jrtype = (opcode == `OP_JALR);
    assign lui    = (opcode == `OP_LUI);
    assign aupc   = (opcode == `OP_AUIPC);

    assign imm_shift = itype & (funct3[1:0] == 2'b01);
    assign imm_sra   = imm_shift & funct3[2] & f7_alt;

    // legal encodings only, mul/div (funct7 0000001) drops out of r_ok
    assign r_ok  = rtype & (f7_zero | (f7_alt & (funct3 == 3'b000 | funct3 == 3'b101)));
    assign i_ok  = itype & (~imm_shift | f7_zero | imm_sra);
    assign l_ok  = ltype & (funct3[1:0] != 2'b11) & ~(funct3[2] & funct3[1]);  // 0,1,2,4,5
    assign s_ok  = stype & ~funct3[2] & (funct3[1:0] != 2'b11);                // 0,1,2
    assign b_ok  = btype & (funct3[2:1] != 2'b01);                             // no 010/011
    assign jr_ok = jrtype & (funct3 == 3'b000);

    assign ctrl.rd_we  = r_ok | i_ok | l_ok | jtype | jr_ok | lui | aupc;
    assign ctrl.branch = b_ok;
    assign ctrl.bneq   = b_ok & (funct3 == 3'b001);  // bne
    assign ctrl.jal    = jtype;
    assign ctrl.jalr   = jr_ok;

    assign ctrl.b_sel = imm_shift ? `B_SHAMT :
                        (itype | ltype | stype | jrtype) ? `B_IMM : `B_REG;

    always_comb begin
        ctrl.alu_fn = `ALU_ADD;                      // address add for ld/st/jalr
        if (rtype) begin
            ctrl.alu_fn = {funct7[5], funct3};       // bit 30 picks sub/sra
        end else if (itype) begin
            ctrl.alu_fn = {imm_sra, funct3};         // bit 30 is imm data unless srai
        end else if (btype) begin
            case (funct3)
                3'b100:  ctrl.alu_fn = `ALU_BLT;
                3'b101:  ctrl.alu_fn = `ALU_BGE;
                3'b110:  ctrl.alu_fn = `ALU_BLTU;
                3'b111:  ctrl.alu_fn = `ALU_BGEU;
                default: ctrl.alu_fn = `ALU_BEQ;     // beq, bne
            endcase
        end
    end

    always_comb begin
        if (jtype | jr_ok) begin
            ctrl.wb_sel = `WB_PC4;    // link
        end else if (lui) begin
            ctrl.wb_sel = `WB_IMM;
        end else if (aupc) begin
            ctrl.wb_sel = `WB_AUIPC;
        end else if (ltype) begin
            ctrl.wb_sel = `WB_LOAD;
        end else begin
            ctrl.wb_sel = `WB_ALU;
        end
    end

    always_comb begin
        ctrl.mem_op = `MEM_NONE;
        if (l_ok) begin
            case (funct3)
                3'b000:  ctrl.mem_op = `MEM_LB;
                3'b001:  ctrl.mem_op = `MEM_LH;
                3'b010:  ctrl.mem_op = `MEM_LW;
                3'b100:  ctrl.mem_op = `MEM_LBU;
                default: ctrl.mem_op = `MEM_LHU;   // only 101 left
            endcase
        end else if (s_ok) begin
            case (funct3)
                3'b000:  ctrl.mem_op = `MEM_SB;
                3'b001:  ctrl.mem_op = `MEM_SH;
                default: ctrl.mem_op = `MEM_SW;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module imm_gen import rv_pkg::*; (
    input  word_t i_instr,
    output word_t o_imm    // sign-extended immediate
);

    logic [6:0] opcode;
    logic       sign;      // instr[31] is the sign bit in every format

    assign opcode = i_instr[6:0];
    assign sign   = i_instr[31];

    always_comb begin
        case (opcode)
            `OP_LOAD, `OP_IMM, `OP_JALR: begin    // I
                o_imm = {{20{sign}}, i_instr[31:20]};
            end
            `OP_STORE: begin                      // S
                o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
            end
            `OP_BRANCH: begin                     // B, half-word aligned
                o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
            end
            `OP_LUI, `OP_AUIPC: begin             // U
                o_imm = {i_instr[31:12], 12'b0};
            end
            `OP_JAL: begin                        // J
                o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
            end
            default: o_imm = '0;                  // R and unknown
        endcase
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module reg_file import rv_pkg::*; (
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    input  reg_addr_t i_rd_addr,
    input  logic      i_rd_we,
    input  word_t     i_rd_data,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    word_t regs [1:2**`REG_AW-1];  // x1..x31, x0 has no storage

    // write at the edge, held off while in reset
    always_ff @(posedge i_clk) begin
        if (i_arst_n && i_rd_we && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // combinational reads, x0 reads zero
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module alu import rv_pkg::*; (
    input  alu_fn_t i_fn,
    input  logic    i_bneq,    // flip equal test for bne
    input  word_t   i_a,
    input  word_t   i_b,
    output word_t   o_result,
    output logic    o_cond     // branch taken
);

    logic [$clog2(`XLEN)-1:0] shamt;
    logic                     lt_s;  // signed a < b
    logic                     lt_u;  // unsigned a < b
    logic                     eq;

    assign shamt = i_b[$clog2(`XLEN)-1:0];  // low 5 bits only
    assign lt_s  = $signed(i_a) < $signed(i_b);
    assign lt_u  = i_a < i_b;
    assign eq    = (i_a == i_b);

    always_comb begin
        case (i_fn)
            `ALU_ADD:  o_result = i_a + i_b;
            `ALU_SLL:  o_result = i_a << shamt;
            `ALU_SLT:  o_result = {{(`XLEN-1){1'b0}}, lt_s};
            `ALU_SLTU: o_result = {{(`XLEN-1){1'b0}}, lt_u};
            `ALU_XOR:  o_result = i_a ^ i_b;
            `ALU_SRL:  o_result = i_a >> shamt;
            `ALU_OR:   o_result = i_a | i_b;
            `ALU_AND:  o_result = i_a & i_b;
            `ALU_SRA:  o_result = $signed(i_a) >>> shamt;       // keeps sign
            `ALU_SUB, `ALU_BGE, `ALU_BGEU: o_result = i_a - i_b;
            default:   o_result = '0;
        endcase
    end

    // branch outcome, only looked at when the decoder flags a branch
    always_comb begin
        case (i_fn)
            `ALU_BEQ:  o_cond = eq ^ i_bneq;
            `ALU_BLT:  o_cond = lt_s;
            `ALU_BGE:  o_cond = ~lt_s;
            `ALU_BLTU: o_cond = lt_u;
            `ALU_BGEU: o_cond = ~lt_u;
            default:   o_cond = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_core import rv_pkg::*; (
    input  logic      i_clk,
    input  logic      i_arst_n,
    output word_t     o_pc,          // fetch address
    input  word_t     i_instr,       // instruction at o_pc, same cycle
    output word_t     o_dmem_addr,
    output word_t     o_dmem_wdata,  // lane-replicated store data
    output byte_en_t  o_dmem_be,
    output logic      o_dmem_we,
    input  word_t     i_dmem_rdata,  // aligned word, same cycle
    output logic      o_wb_valid,    // trace of the rd write
    output reg_addr_t o_wb_addr,
    output word_t     o_wb_data
);

    ctrl_if ctrl ();

    word_t      pc, next_pc, pc_plus4, pc_plus_imm;
    word_t      imm, rs1_data, rs2_data, alu_b, alu_result;
    word_t      lane;        // addressed byte moved to bit 0
    word_t      load_data, wb_data;
    logic       cond;
    logic       is_store;
    logic [1:0] byte_off;

    instr_decoder i_instr_decoder (.i_instr(i_instr), .ctrl(ctrl.dec));

    imm_gen i_imm_gen (.i_instr(i_instr), .o_imm(imm));

    reg_file i_reg_file (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs1_addr (i_instr[19:15]),
        .i_rs2_addr (i_instr[24:20]),
        .i_rd_addr  (i_instr[11:7]),
        .i_rd_we    (o_wb_valid),
        .i_rd_data  (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    always_comb begin
        case (ctrl.b_sel)
            `B_IMM:   alu_b = imm;
            `B_SHAMT: alu_b = {{(`XLEN-5){1'b0}}, imm[4:0]};  // srai bit 30 dropped
            default:  alu_b = rs2_data;
        endcase
    end

    alu i_alu (
        .i_fn     (ctrl.alu_fn),
        .i_bneq   (ctrl.bneq),
        .i_a      (rs1_data),
        .i_b      (alu_b),
        .o_result (alu_result),
        .o_cond   (cond)
    );

    assign pc_plus4    = pc + 32'd4;
    assign pc_plus_imm = pc + imm;     // branch/jal target, also auipc

    always_comb begin
        if (ctrl.jal || (ctrl.branch && cond)) begin
            next_pc = pc_plus_imm;
        end else if (ctrl.jalr) begin
            next_pc = {alu_result[`XLEN-1:1], 1'b0};   // bit 0 cleared
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    assign o_pc = pc;

    // store lanes
    assign byte_off    = alu_result[1:0];
    assign o_dmem_addr = alu_result;

    always_comb begin
        is_store     = 1'b1;
        o_dmem_be    = '0;
        o_dmem_wdata = rs2_data;
        case (ctrl.mem_op)
            `MEM_SB: begin
                o_dmem_be    = 4'b0001 << byte_off;
                o_dmem_wdata = {4{rs2_data[7:0]}};
            end
            `MEM_SH: begin
                o_dmem_be    = 4'b0011 << {byte_off[1], 1'b0};
                o_dmem_wdata = {2{rs2_data[15:0]}};
            end
            `MEM_SW: o_dmem_be = 4'b1111;
            default: is_store = 1'b0;   // loads and none
        endcase
    end

    assign o_dmem_we = i_arst_n & is_store;   // quiet during reset

    // load lane extract and extend
    assign lane = i_dmem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (ctrl.mem_op)
            `MEM_LB:  load_data = {{24{lane[7]}}, lane[7:0]};
            `MEM_LH:  load_data = {{16{lane[15]}}, lane[15:0]};
            `MEM_LBU: load_data = {24'b0, lane[7:0]};
            `MEM_LHU: load_data = {16'b0, lane[15:0]};
            default:  load_data = i_dmem_rdata;       // lw
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            `WB_PC4:   wb_data = pc_plus4;
            `WB_IMM:   wb_data = imm;
            `WB_AUIPC: wb_data = pc_plus_imm;
            `WB_LOAD:  wb_data = load_data;
            default:   wb_data = alu_result;
        endcase
    end

    // x0 targets count as no write
    assign o_wb_valid = i_arst_n & ctrl.rd_we & (i_instr[11:7] != '0);
    assign o_wb_addr  = i_instr[11:7];
    assign o_wb_data  = wb_data;

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

// free-running clock plus a reset that can be restarted
module tb_clk_gen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 10
) (
    input  logic i_rst_req,   // sampled at the edge, restarts reset
    output logic o_clk,
    output logic o_arst_n
);

    int rst_cnt;              // edges left with reset low

    initial begin
        o_clk    = 1'b0;
        o_arst_n <= 1'b0;     // in reset from time 0
        rst_cnt  <= RST_CYCLES;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

    always @(posedge o_clk) begin
        if (i_rst_req) begin
            o_arst_n <= 1'b0;
            rst_cnt  <= RST_CYCLES;
        end else if (rst_cnt > 1) begin
            rst_cnt <= rst_cnt - 1;
        end else if (rst_cnt == 1) begin
            rst_cnt  <= 0;
            o_arst_n <= 1'b1;  // release on the last counted edge
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module tb_rv_core import rv_pkg::*; ();

    localparam int CLK_PERIOD_NS   = 4;
    localparam int IMEM_WORDS      = 256;
    localparam int DMEM_WORDS      = 64;
    localparam int WATCHDOG_CYCLES = 2000;  // 6 tests under 40 cycles each, wide margin
    localparam int unsigned SEED   = 32'h0995ebcd;

    logic      clk, arst_n, rst_req;
    word_t     pc, instr, dmem_addr, dmem_wdata, dmem_rdata, wb_data;
    byte_en_t  dmem_be;
    logic      dmem_we, wb_valid;
    reg_addr_t wb_addr;

    word_t imem [0:IMEM_WORDS-1];
    word_t dmem [0:DMEM_WORDS-1];

    // program under construction and what each step should do
    word_t     p_addr[$], p_instr[$], e_data[$], e_saddr[$], e_sdata[$];
    logic      e_wb[$], e_we[$];
    reg_addr_t e_rd[$];
    byte_en_t  e_be[$];
    word_t     mreg [0:31];   // register model
    word_t     mpc;           // address of the next emitted instruction

    int errors, tests_run, tests_failed;
    int unsigned seed_ret;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(10)) i_tb_clk_gen (
        .i_rst_req (rst_req),
        .o_clk     (clk),
        .o_arst_n  (arst_n)
    );

    rv_core i_rv_core (
        .i_clk        (clk),
        .i_arst_n     (arst_n),
        .o_pc         (pc),
        .i_instr      (instr),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_dmem_be    (dmem_be),
        .o_dmem_we    (dmem_we),
        .i_dmem_rdata (dmem_rdata),
        .o_wb_valid   (wb_valid),
        .o_wb_addr    (wb_addr),
        .o_wb_data    (wb_data)
    );

    // both memories answer within the cycle
    assign instr      = imem[pc[9:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_be[b]) begin
                    dmem[dmem_addr[7:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    // instruction encoders
    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
    endfunction

    function automatic word_t enc_b(input word_t off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic word_t enc_u(input word_t upper, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {upper[31:12], rd, op};
    endfunction

    function automatic word_t enc_j(input word_t off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // branch outcome by funct3
    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t lane_mask(input byte_en_t be);
        word_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_be(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic fill_memories();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {4'h0, 8'(i), 20'h00013};   // addi x0, x0, index
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= {16'hd5c3, 8'(i), 8'(~i)};
        end
    endtask

    task automatic new_program();
        p_addr.delete();
        p_instr.delete();
        e_wb.delete();
        e_rd.delete();
        e_data.delete();
        e_we.delete();
        e_saddr.delete();
        e_be.delete();
        e_sdata.delete();
        mpc     = `RESET_PC;
        mreg[0] = '0;
    endtask

    task automatic push_step(input word_t ins, input logic wb, input reg_addr_t rd,
                             input word_t data, input logic we, input word_t saddr,
                             input byte_en_t be, input word_t sdata, input word_t npc);
        p_addr.push_back(mpc);
        p_instr.push_back(ins);
        e_wb.push_back(wb);
        e_rd.push_back(rd);
        e_data.push_back(data);
        e_we.push_back(we);
        e_saddr.push_back(saddr);
        e_be.push_back(be);
        e_sdata.push_back(sdata);
        if (wb && rd != '0) begin
            mreg[rd] = data;
        end
        mpc = npc;
    endtask

    task automatic emit(input word_t ins, input logic wb, input reg_addr_t rd, input word_t data);
        push_step(ins, wb, rd, data, 1'b0, '0, '0, '0, mpc + 4);
    endtask

    task automatic emit_jump(input word_t ins, input logic wb, input reg_addr_t rd,
                             input word_t data, input word_t npc);
        push_step(ins, wb, rd, data, 1'b0, '0, '0, '0, npc);
    endtask

    task automatic emit_store(input word_t ins, input word_t addr, input byte_en_t be,
                              input word_t sdata);
        push_step(ins, 1'b0, '0, '0, 1'b1, addr, be, sdata, mpc + 4);
    endtask

    // lui + addi, lui part rounded so the sign-extended low 12 bits land on v
    task automatic li(input reg_addr_t rd, input word_t v);
        word_t hi;
        hi = (v + 32'h800) & 32'hffff_f000;
        emit(enc_u(hi, rd, `OP_LUI), 1'b1, rd, hi);
        emit(enc_i(v[11:0], rd, 3'b000, rd, `OP_IMM), 1'b1, rd, v);
    endtask

    task automatic branch_case(input logic [2:0] f3, input reg_addr_t rs1,
                               input reg_addr_t rs2, input word_t off);
        word_t npc;
        npc = branch_taken(f3, mreg[rs1], mreg[rs2]) ? mpc + off : mpc + 4;
        emit_jump(enc_b(off, rs2, rs1, f3), 1'b0, '0, '0, npc);
    endtask

    // reset, load while held, then step one edge per instruction
    task automatic run_program(input string name);
        int errs_before;
        errs_before = errors;
        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        @(negedge clk);                // reset now low, outputs settled
        fill_memories();
        for (int i = 0; i < p_instr.size(); i++) begin
            imem[p_addr[i][9:2]] = p_instr[i];
        end
        check_word("o_pc", pc, `RESET_PC);
        check_bit("o_dmem_we", dmem_we, 1'b0);
        check_bit("o_wb_valid", wb_valid, 1'b0);
        while (arst_n !== 1'b1) begin
            @(negedge clk);
        end
        for (int i = 0; i < p_instr.size(); i++) begin
            check_word("o_pc", pc, p_addr[i]);   // first step is right after release
            check_bit("o_wb_valid", wb_valid, e_wb[i]);
            if (e_wb[i]) begin
                check_reg("o_wb_addr", wb_addr, e_rd[i]);
                check_word("o_wb_data", wb_data, e_data[i]);
            end
            check_bit("o_dmem_we", dmem_we, e_we[i]);
            if (e_we[i]) begin
                check_word("o_dmem_addr", dmem_addr, e_saddr[i]);
                check_be("o_dmem_be", dmem_be, e_be[i]);
                check_word("o_dmem_wdata", dmem_wdata & lane_mask(e_be[i]), e_sdata[i]);
            end
            @(negedge clk);                      // retire at the edge in between
        end
        check_word("o_pc", pc, mpc);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("test %-8s %s, %0d mismatches", name,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
    endtask

    task automatic test_reset();
        new_program();
        emit_store(enc_s(12'd0, 5'd0, 5'd0, 3'b010), 32'h0, 4'b1111, 32'h0);  // sits at pc 0 in reset
        for (int k = 1; k <= 6; k++) begin
            emit(enc_i(12'(k * 3), 5'd0, 3'b000, 5'(k), `OP_IMM), 1'b1, 5'(k), k * 3);
        end
        emit(32'h0000_0f80, 1'b0, '0, '0);                           // unknown opcode, rd x31
        emit(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd9), 1'b0, '0, '0);  // mul, no M ext
        emit(32'hffff_ffff, 1'b0, '0, '0);
        emit(enc_i(12'd1, 5'd1, 3'b000, 5'd9, `OP_IMM), 1'b1, 5'd9, mreg[1] + 1);
        run_program("reset");
    endtask

    task automatic test_alu();
        logic [11:0] imm;
        new_program();
        imm = 12'($urandom);
        li(5'd1, $urandom);
        li(5'd2, $urandom);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, mreg[1] + mreg[2]);
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, mreg[1] - mreg[2]);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), 1'b1, 5'd5, mreg[1] ^ mreg[2]);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 1'b1, 5'd6, mreg[1] | mreg[2]);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd7), 1'b1, 5'd7, mreg[1] & mreg[2]);
        emit(enc_i(imm, 5'd1, 3'b000, 5'd8, `OP_IMM), 1'b1, 5'd8, mreg[1] + sext12(imm));
        emit(enc_i(imm, 5'd1, 3'b100, 5'd9, `OP_IMM), 1'b1, 5'd9, mreg[1] ^ sext12(imm));
        emit(enc_i(imm, 5'd2, 3'b110, 5'd10, `OP_IMM), 1'b1, 5'd10, mreg[2] | sext12(imm));
        emit(enc_i(imm, 5'd2, 3'b111, 5'd11, `OP_IMM), 1'b1, 5'd11, mreg[2] & sext12(imm));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 1'b0, '0, '0);     // x0 discards
        emit(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd12), 1'b1, 5'd12, mreg[2]);
        run_program("alu");
    endtask

    task automatic test_shift();
        word_t       a, b;
        logic [4:0]  s;
        logic [11:0] imm;
        new_program();
        a   = $urandom | 32'h8000_0000;   // negative, for sra
        b   = $urandom | 32'h0000_0020;   // bits above the shift amount set
        s   = 5'($urandom);
        imm = 12'($urandom);
        li(5'd1, a);
        li(5'd2, b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), 1'b1, 5'd3, a << b[4:0]);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd4), 1'b1, 5'd4, a >> b[4:0]);
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd5), 1'b1, 5'd5, word_t'($signed(a) >>> b[4:0]));
        emit(enc_i({7'h00, s}, 5'd1, 3'b001, 5'd6, `OP_IMM), 1'b1, 5'd6, a << s);
        emit(enc_i({7'h00, s}, 5'd1, 3'b101, 5'd7, `OP_IMM), 1'b1, 5'd7, a >> s);
        emit(enc_i({7'h20, s}, 5'd1, 3'b101, 5'd8, `OP_IMM), 1'b1, 5'd8,
             word_t'($signed(a) >>> s));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd9), 1'b1, 5'd9, word_t'($signed(a) < $signed(b)));
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd10), 1'b1, 5'd10,
             word_t'($signed(b) < $signed(a)));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd11), 1'b1, 5'd11, word_t'(a < b));
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd12), 1'b1, 5'd12, word_t'(b < a));
        emit(enc_i(imm, 5'd1, 3'b010, 5'd13, `OP_IMM), 1'b1, 5'd13,
             word_t'($signed(a) < $signed(sext12(imm))));
        emit(enc_i(imm, 5'd1, 3'b011, 5'd14, `OP_IMM), 1'b1, 5'd14, word_t'(a < sext12(imm)));
        run_program("shift");
    endtask

    task automatic test_mem();
        word_t v;
        new_program();
        v = ($urandom | 32'h8000_0080) & 32'hffff_7fff;  // byte 0 and top half negative
        li(5'd1, 32'h40);                                 // base
        li(5'd2, v);
        emit_store(enc_s(12'd0, 5'd2, 5'd1, 3'b010), 32'h40, 4'b1111, v);
        emit_store(enc_s(12'd5, 5'd2, 5'd1, 3'b000), 32'h45, 4'b0010, {16'h0, v[7:0], 8'h0});
        emit_store(enc_s(12'd10, 5'd2, 5'd1, 3'b001), 32'h4a, 4'b1100, {v[15:0], 16'h0});
        emit(enc_i(12'd0, 5'd1, 3'b010, 5'd3, `OP_LOAD), 1'b1, 5'd3, v);
        emit(enc_i(12'd1, 5'd1, 3'b000, 5'd4, `OP_LOAD), 1'b1, 5'd4, {{24{v[15]}}, v[15:8]});
        emit(enc_i(12'd1, 5'd1, 3'b100, 5'd5, `OP_LOAD), 1'b1, 5'd5, {24'h0, v[15:8]});
        emit(enc_i(12'd5, 5'd1, 3'b000, 5'd6, `OP_LOAD), 1'b1, 5'd6, {{24{v[7]}}, v[7:0]});
        emit(enc_i(12'd5, 5'd1, 3'b100, 5'd7, `OP_LOAD), 1'b1, 5'd7, {24'h0, v[7:0]});
        emit(enc_i(12'd10, 5'd1, 3'b001, 5'd8, `OP_LOAD), 1'b1, 5'd8, {{16{v[15]}}, v[15:0]});
        emit(enc_i(12'd10, 5'd1, 3'b101, 5'd9, `OP_LOAD), 1'b1, 5'd9, {16'h0, v[15:0]});
        emit(enc_i(12'd2, 5'd1, 3'b001, 5'd10, `OP_LOAD), 1'b1, 5'd10, {{16{v[31]}}, v[31:16]});
        emit(enc_i(12'd2, 5'd1, 3'b101, 5'd11, `OP_LOAD), 1'b1, 5'd11, {16'h0, v[31:16]});
        run_program("mem");
    endtask

    task automatic test_branch();
        new_program();
        li(5'd1, $urandom | 32'h8000_0000);   // negative, big unsigned
        li(5'd2, $urandom & 32'h7fff_ffff);   // positive
        for (int k = 0; k < 8; k++) begin
            if (k != 2 && k != 3) begin       // 010 and 011 are not branches
                branch_case(3'(k), 5'd1, 5'd2, 32'd8);
                branch_case(3'(k), 5'd2, 5'd1, 32'd12);
                branch_case(3'(k), 5'd1, 5'd1, 32'd8);
            end
        end
        emit_jump(enc_j(32'd64, 5'd0), 1'b0, '0, '0, mpc + 64);
        branch_case(3'b000, 5'd0, 5'd0, -32'sd32);   // backward into the gap
        emit(enc_i(12'd1, 5'd2, 3'b000, 5'd8, `OP_IMM), 1'b1, 5'd8, mreg[2] + 1);
        run_program("branch");
    endtask

    task automatic test_jump();
        word_t t, u;
        new_program();
        emit_jump(enc_j(32'd16, 5'd1), 1'b1, 5'd1, mpc + 4, mpc + 16);
        t = mpc + 8 + 32;                     // past li and a gap
        li(5'd3, t + 1 - 5);                  // odd sum, bit 0 must clear
        emit_jump(enc_i(12'd5, 5'd3, 3'b000, 5'd2, `OP_JALR), 1'b1, 5'd2, mpc + 4, t);
        u = $urandom & 32'hffff_f000;
        emit(enc_u(u, 5'd4, `OP_LUI), 1'b1, 5'd4, u);
        emit(enc_u(u, 5'd5, `OP_AUIPC), 1'b1, 5'd5, mpc + u);
        emit_jump(enc_j(-32'sd12, 5'd6), 1'b1, 5'd6, mpc + 4, mpc - 12);
        emit(enc_i(12'd7, 5'd6, 3'b000, 5'd7, `OP_IMM), 1'b1, 5'd7, mreg[6] + 7);
        run_program("jump");
    endtask

    initial begin
        rst_req      <= 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        fill_memories();
        seed_ret = $urandom(SEED);
        test_reset();
        test_alu();
        test_shift();
        test_mem();
        test_branch();
        test_jump();
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog ran out after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/rv_pkg.sv
design/ctrl_if.sv
design/instr_decoder.sv
design/imm_gen.sv
design/reg_file.sv
design/alu.sv
design/rv_core.sv
testbench/tb_clk_gen.sv
testbench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - design

sources:
  - files:
      - design/rv_pkg.sv
      - design/ctrl_if.sv
      - design/instr_decoder.sv
      - design/imm_gen.sv
      - design/reg_file.sv
      - design/alu.sv
      - design/rv_core.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_rv_core.sv
